// File: Makefile
# Verilator flow for the I2C master

VERILATOR ?= verilator
TOP       ?= tb_i2c_master
RTL_TOP   ?= i2c_master_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
SIM_FLAGS ?= --binary --timing --assert
RTL_SRCS  ?= i2c_pkg.sv i2c_bit_timer.sv i2c_byte_shifter.sv i2c_sequencer.sv \
             i2c_wb_regs.sv i2c_master_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: i2c_bit_timer.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_timer
    import i2c_pkg::*;
(
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_run,
    input  wire  i_hold_high,
    output logic o_scl,
    output logic o_advance,
    output logic o_sample
);

    logic [QCNT_W-1:0] clk_cnt;
    logic [1:0]        quarter;
    logic              boundary;

    // One clock at the start of every quarter
    assign boundary  = i_run && (clk_cnt == '0);

    // Middle of the low half, SDA may change here
    assign o_advance = boundary && (quarter == 2'd1);
    // Middle of the high half, SDA is stable
    assign o_sample  = boundary && (quarter == 2'd3);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clk_cnt <= '0;
            quarter <= 2'd0;
            o_scl   <= 1'b1;
        end else if (!i_run) begin
            // Idle bus, next run starts from quarter zero
            clk_cnt <= '0;
            quarter <= 2'd0;
            o_scl   <= 1'b1;
        end else begin
            if (clk_cnt == QCNT_W'(CLKS_PER_QUARTER - 1)) begin
                clk_cnt <= '0;
                quarter <= quarter + 2'd1;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end

            // Hold high keeps SCL up for START and STOP periods
            if (boundary && quarter == 2'd0 && !i_hold_high) begin
                o_scl <= 1'b0;
            end else if (boundary && quarter == 2'd2) begin
                o_scl <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: i2c_byte_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_shifter (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_load,
    input  wire        i_tx_dir,
    input  wire  [7:0] i_tx_byte,
    input  wire        i_advance,
    input  wire        i_sample,
    input  wire        i_sda,
    output logic       o_sda_bit,
    output logic       o_done,
    output logic [7:0] o_rx_byte
);

    logic [7:0] sreg;
    logic [2:0] bit_cnt;
    logic       active;
    logic       tx_q;

    assign o_rx_byte = sreg;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active    <= 1'b0;
            tx_q      <= 1'b1;
            bit_cnt   <= 3'd0;
            o_sda_bit <= 1'b1;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_load) begin
                active  <= 1'b1;
                tx_q    <= i_tx_dir;
                bit_cnt <= 3'd0;
            end else begin
                // Release SDA outside a transmitted byte, also for ACK slots
                if (i_advance) begin
                    o_sda_bit <= (active && tx_q) ? sreg[7] : 1'b1;
                end
                // Bits are counted on the SCL high half in both directions
                if (i_sample && active) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        active <= 1'b0;
                        o_done <= 1'b1;
                    end
                end
            end
        end
    end

    // MSB first out, MSB first in
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            sreg <= i_tx_byte;
        end else if (active && tx_q && i_advance) begin
            sreg <= {sreg[6:0], 1'b0};
        end else if (active && !tx_q && i_sample) begin
            sreg <= {sreg[6:0], i_sda};
        end
    end

endmodule

`default_nettype wire

// File: i2c_master_top.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master_top
    import i2c_pkg::*;
(
    input  wire     i_clk,
    input  wire     i_rst_n,
    input  wire     wb_req_t i_wb,
    output wb_rsp_t o_wb,
    input  wire     i_sda,
    output logic    o_sda,
    output logic    o_scl
);

    i2c_req_t   req;
    i2c_rsp_t   rsp;
    logic       run;
    logic       hold_high;
    logic       advance;
    logic       sample;
    logic       load;
    logic       tx_dir;
    logic       byte_done;
    logic       sda_bit;
    logic       sda_ctl;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;

    // Open-drain, either side may pull SDA low
    assign o_sda = sda_ctl & sda_bit;

    i2c_wb_regs u_regs (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wb    (i_wb),
        .o_wb    (o_wb),
        .i_rsp   (rsp),
        .o_req   (req)
    );

    i2c_sequencer u_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (req),
        .o_rsp       (rsp),
        .i_advance   (advance),
        .i_sample    (sample),
        .i_sda       (i_sda),
        .i_byte_done (byte_done),
        .i_rx_byte   (rx_byte),
        .o_run       (run),
        .o_hold_high (hold_high),
        .o_load      (load),
        .o_tx_dir    (tx_dir),
        .o_tx_byte   (tx_byte),
        .o_sda_ctl   (sda_ctl)
    );

    i2c_bit_timer u_timer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_run       (run),
        .i_hold_high (hold_high),
        .o_scl       (o_scl),
        .o_advance   (advance),
        .o_sample    (sample)
    );

    i2c_byte_shifter u_shift (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_load    (load),
        .i_tx_dir  (tx_dir),
        .i_tx_byte (tx_byte),
        .i_advance (advance),
        .i_sample  (sample),
        .i_sda     (i_sda),
        .o_sda_bit (sda_bit),
        .o_done    (byte_done),
        .o_rx_byte (rx_byte)
    );

endmodule

`default_nettype wire

// File: i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // Bus timing, four quarters per SCL period
    localparam int CLK_HZ           = 250_000_000;
    localparam int I2C_HZ           = 12_500_000;
    localparam int CLKS_PER_QUARTER = CLK_HZ / (4 * I2C_HZ);
    localparam int QCNT_W           = $clog2(CLKS_PER_QUARTER);

    // Wishbone word addresses
    localparam logic [2:0] REG_SLAVE  = 3'd0;
    localparam logic [2:0] REG_ADDR   = 3'd1;
    localparam logic [2:0] REG_WDATA  = 3'd2;
    localparam logic [2:0] REG_CMD    = 3'd3;
    localparam logic [2:0] REG_STATUS = 3'd4;
    localparam logic [2:0] REG_RDATA  = 3'd5;

    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_NACK_BIT = 1;

    // Which byte of the transaction goes out next
    localparam logic [1:0] SEG_SLAVE_W = 2'd0;
    localparam logic [1:0] SEG_REG     = 2'd1;
    localparam logic [1:0] SEG_DATA    = 2'd2;
    localparam logic [1:0] SEG_SLAVE_R = 2'd3;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2
    } i2c_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_SEND,
        ST_GET_ACK,
        ST_RECV,
        ST_SEND_NACK,
        ST_STOP_PRE,
        ST_STOP
    } i2c_state_e;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [2:0] adr;
        logic [7:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
    } wb_rsp_t;

    typedef struct packed {
        logic       start;
        i2c_cmd_e   op;
        logic [6:0] slave;
        logic [7:0] addr;
        logic [7:0] wdata;
    } i2c_req_t;

    typedef struct packed {
        logic       busy;
        logic       nack;
        logic [7:0] rdata;
    } i2c_rsp_t;

endpackage

`default_nettype wire

// File: i2c_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_sequencer
    import i2c_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire  i2c_req_t i_req,
    output i2c_rsp_t   o_rsp,
    input  wire        i_advance,
    input  wire        i_sample,
    input  wire        i_sda,
    input  wire        i_byte_done,
    input  wire  [7:0] i_rx_byte,
    output logic       o_run,
    output logic       o_hold_high,
    output logic       o_load,
    output logic       o_tx_dir,
    output logic [7:0] o_tx_byte,
    output logic       o_sda_ctl
);

    i2c_state_e state;
    i2c_cmd_e   op_q;
    logic [1:0] seg;
    logic       busy_q;
    logic       nack_q;
    logic [6:0] slave_q;
    logic [7:0] addr_q;
    logic [7:0] wdata_q;
    logic [7:0] rdata_q;

    assign o_rsp = '{busy: busy_q, nack: nack_q, rdata: rdata_q};

    // Byte for the shifter, seg already points at it when load is high
    always_comb begin
        case (seg)
            SEG_SLAVE_W: o_tx_byte = {slave_q, 1'b0};
            SEG_REG:     o_tx_byte = addr_q;
            SEG_DATA:    o_tx_byte = wdata_q;
            default:     o_tx_byte = {slave_q, 1'b1};
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && i_req.start) begin
            slave_q <= i_req.slave;
            addr_q  <= i_req.addr;
            wdata_q <= i_req.wdata;
        end
        if (state == ST_RECV && i_byte_done) begin
            rdata_q <= i_rx_byte;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            op_q        <= CMD_NONE;
            seg         <= SEG_SLAVE_W;
            busy_q      <= 1'b0;
            nack_q      <= 1'b0;
            o_run       <= 1'b0;
            o_hold_high <= 1'b1;
            o_load      <= 1'b0;
            o_tx_dir    <= 1'b1;
            o_sda_ctl   <= 1'b1;
        end else begin
            o_load <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_req.start && i_req.op != CMD_NONE) begin
                        op_q        <= i_req.op;
                        seg         <= SEG_SLAVE_W;
                        busy_q      <= 1'b1;
                        nack_q      <= 1'b0;
                        o_run       <= 1'b1;
                        o_hold_high <= 1'b1;
                        state       <= ST_START;
                    end
                end
                ST_START: begin
                    // SDA falls while SCL is held high
                    if (i_advance) begin
                        o_sda_ctl <= 1'b0;
                    end
                    if (i_sample) begin
                        o_load      <= 1'b1;
                        o_tx_dir    <= 1'b1;
                        o_hold_high <= 1'b0;
                        state       <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    // Hand SDA to the shifter on its first bit
                    if (i_advance) begin
                        o_sda_ctl <= 1'b1;
                    end
                    if (i_byte_done) begin
                        state <= ST_GET_ACK;
                    end
                end
                ST_GET_ACK: begin
                    if (i_sample) begin
                        if (i_sda) begin
                            // No slave answered, abort with STOP
                            nack_q <= 1'b1;
                            state  <= ST_STOP_PRE;
                        end else begin
                            case (seg)
                                SEG_SLAVE_W: begin
                                    seg      <= SEG_REG;
                                    o_load   <= 1'b1;
                                    o_tx_dir <= 1'b1;
                                    state    <= ST_SEND;
                                end
                                SEG_REG: begin
                                    if (op_q == CMD_WRITE) begin
                                        seg      <= SEG_DATA;
                                        o_load   <= 1'b1;
                                        o_tx_dir <= 1'b1;
                                        state    <= ST_SEND;
                                    end else begin
                                        state <= ST_STOP_PRE;
                                    end
                                end
                                SEG_DATA: state <= ST_STOP_PRE;
                                default: begin
                                    o_load   <= 1'b1;
                                    o_tx_dir <= 1'b0;
                                    state    <= ST_RECV;
                                end
                            endcase
                        end
                    end
                end
                ST_RECV: begin
                    if (i_byte_done) begin
                        state <= ST_SEND_NACK;
                    end
                end
                // SDA stays released, which the slave reads as NACK
                ST_SEND_NACK: begin
                    if (i_sample) begin
                        state <= ST_STOP_PRE;
                    end
                end
                ST_STOP_PRE: begin
                    if (i_advance) begin
                        o_sda_ctl <= 1'b0;
                    end
                    if (i_sample) begin
                        o_hold_high <= 1'b1;
                        state       <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    // SDA rises while SCL is held high
                    if (i_advance) begin
                        o_sda_ctl <= 1'b1;
                    end
                    if (i_sample) begin
                        if (op_q == CMD_READ && seg == SEG_REG && !nack_q) begin
                            seg   <= SEG_SLAVE_R;
                            state <= ST_START;
                        end else begin
                            busy_q <= 1'b0;
                            o_run  <= 1'b0;
                            state  <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: i2c_slave_model.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_model (
    input  wire        i_clk,
    input  wire        i_scl,
    input  wire        i_sda,
    input  wire  [6:0] i_addr,
    output logic       o_sda
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_ADDR,
        PH_REG,
        PH_WDATA,
        PH_RDATA
    } phase_e;

    logic [7:0] mem [0:255];
    phase_e     phase;
    logic [3:0] bit_n;
    logic [7:0] shift;
    logic [7:0] ptr;
    logic       scl_q;
    logic       sda_q;
    logic       saw_read_addr;
    logic       master_nack;
    int         start_count;
    int         stop_count;
    integer     seed;

    initial begin
        seed = 32'h7be88802;
        for (int i = 0; i < 256; i++) begin
            mem[i] <= 8'($random(seed));
        end
        phase         <= PH_IDLE;
        bit_n         <= 4'd0;
        shift         <= 8'h00;
        ptr           <= 8'h00;
        scl_q         <= 1'b1;
        sda_q         <= 1'b1;
        o_sda         <= 1'b1;
        saw_read_addr <= 1'b0;
        master_nack   <= 1'b0;
        start_count   <= 0;
        stop_count    <= 0;
    end

    // Bus is oversampled with the system clock, edges show up one clock late
    always @(posedge i_clk) begin
        scl_q <= i_scl;
        sda_q <= i_sda;
        if (scl_q && i_scl && sda_q && !i_sda) begin
            // START
            phase       <= PH_ADDR;
            bit_n       <= 4'd0;
            o_sda       <= 1'b1;
            start_count <= start_count + 1;
        end else if (scl_q && i_scl && !sda_q && i_sda) begin
            // STOP
            phase      <= PH_IDLE;
            o_sda      <= 1'b1;
            stop_count <= stop_count + 1;
        end else if (phase != PH_IDLE && !scl_q && i_scl) begin
            if (bit_n < 4'd8) begin
                shift <= {shift[6:0], i_sda};
            end else if (phase == PH_RDATA) begin
                // High in the ninth slot means the master did not acknowledge
                master_nack <= i_sda;
            end
            bit_n <= bit_n + 4'd1;
        end else if (phase != PH_IDLE && scl_q && !i_scl) begin
            if (bit_n == 4'd8) begin
                case (phase)
                    PH_ADDR: begin
                        if (shift[7:1] == i_addr) begin
                            o_sda <= 1'b0;
                            if (shift[0]) begin
                                saw_read_addr <= 1'b1;
                            end
                        end else begin
                            // Not our address
                            phase <= PH_IDLE;
                        end
                    end
                    PH_REG: begin
                        ptr   <= shift;
                        o_sda <= 1'b0;
                    end
                    PH_WDATA: begin
                        mem[ptr] <= shift;
                        o_sda    <= 1'b0;
                    end
                    default: o_sda <= 1'b1;
                endcase
            end else if (bit_n == 4'd9) begin
                bit_n <= 4'd0;
                o_sda <= 1'b1;
                case (phase)
                    PH_ADDR: begin
                        if (shift[0]) begin
                            phase <= PH_RDATA;
                            o_sda <= mem[ptr][7];
                        end else begin
                            phase <= PH_REG;
                        end
                    end
                    PH_REG:  phase <= PH_WDATA;
                    default: phase <= PH_IDLE;
                endcase
            end else if (phase == PH_RDATA) begin
                o_sda <= mem[ptr][3'd7 - bit_n[2:0]];
            end
        end
    end

endmodule

`default_nettype wire

// File: i2c_wb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_wb_regs
    import i2c_pkg::*;
(
    input  wire      i_clk,
    input  wire      i_rst_n,
    input  wire      wb_req_t i_wb,
    output wb_rsp_t  o_wb,
    input  wire      i2c_rsp_t i_rsp,
    output i2c_req_t o_req
);

    logic       served_q;
    logic       ack_q;
    logic       start_q;
    i2c_cmd_e   op_q;
    logic [6:0] slave_q;
    logic [7:0] addr_q;
    logic [7:0] wdata_q;
    logic [7:0] rdat_q;
    logic [7:0] status;
    logic       access;
    logic       cmd_ok;

    // First cycle of a new cycle/strobe pair
    assign access = i_wb.cyc && i_wb.stb && !served_q;
    assign cmd_ok = (i_wb.dat == {6'd0, CMD_WRITE}) || (i_wb.dat == {6'd0, CMD_READ});

    always_comb begin
        status                  = 8'h00;
        status[STATUS_BUSY_BIT] = i_rsp.busy;
        status[STATUS_NACK_BIT] = i_rsp.nack;
    end

    assign o_wb  = '{dat: rdat_q, ack: ack_q};
    assign o_req = '{start: start_q, op: op_q, slave: slave_q, addr: addr_q, wdata: wdata_q};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            served_q <= 1'b0;
            ack_q    <= 1'b0;
            start_q  <= 1'b0;
            op_q     <= CMD_NONE;
        end else begin
            ack_q   <= access;
            start_q <= 1'b0;
            if (access) begin
                served_q <= 1'b1;
            end else if (!(i_wb.cyc && i_wb.stb)) begin
                served_q <= 1'b0;
            end
            // Commands while busy are acked and dropped
            if (access && i_wb.we && i_wb.adr == REG_CMD && cmd_ok && !i_rsp.busy) begin
                start_q <= 1'b1;
                op_q    <= i2c_cmd_e'(i_wb.dat[1:0]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (access && i_wb.we) begin
            case (i_wb.adr)
                REG_SLAVE: slave_q <= i_wb.dat[6:0];
                REG_ADDR:  addr_q  <= i_wb.dat;
                REG_WDATA: wdata_q <= i_wb.dat;
                default: ;
            endcase
        end
        if (access && !i_wb.we) begin
            case (i_wb.adr)
                REG_SLAVE:  rdat_q <= {1'b0, slave_q};
                REG_ADDR:   rdat_q <= addr_q;
                REG_WDATA:  rdat_q <= wdata_q;
                REG_CMD:    rdat_q <= {6'd0, op_q};
                REG_STATUS: rdat_q <= status;
                REG_RDATA:  rdat_q <= i_rsp.rdata;
                default:    rdat_q <= 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk
);

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #2 o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// File: tb_i2c_master.sv
`timescale 1ns/10ps
`default_nettype none

module tb_i2c_master
    import i2c_pkg::*;
();

    localparam logic [6:0] SLAVE_ADDR   = 7'h50;
    localparam logic [6:0] ABSENT_ADDR  = 7'h23;
    localparam int         ACK_TIMEOUT  = 16;
    localparam int         BUSY_TIMEOUT = 2000;

    logic       clk;
    logic       rst_n;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic       dut_sda;
    logic       dut_scl;
    logic       slave_sda;
    logic       sda_bus;
    logic       wb_active;
    logic [7:0] rd;
    logic [7:0] expected;
    int         errors;
    int         errors_at_start;
    int         tests_passed;
    int         tests_failed;
    int         stops_before;
    int         starts_before;

    // Open-drain SDA shared by master and slave
    assign sda_bus   = dut_sda & slave_sda;
    assign wb_active = wb_req.cyc && wb_req.stb;

    tb_clk_gen u_clk (
        .o_clk (clk)
    );

    i2c_master_top DUT (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_wb    (wb_req),
        .o_wb    (wb_rsp),
        .i_sda   (sda_bus),
        .o_sda   (dut_sda),
        .o_scl   (dut_scl)
    );

    i2c_slave_model u_slave (
        .i_clk  (clk),
        .i_scl  (dut_scl),
        .i_sda  (sda_bus),
        .i_addr (SLAVE_ADDR),
        .o_sda  (slave_sda)
    );

    // Wishbone classic handshake rules
    ack_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_active) |=> wb_rsp.ack)
    else begin
        $display("[ERROR] %0t: ack did not follow the new strobe by one cycle", $time);
        errors++;
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
    else begin
        $display("[ERROR] %0t: ack held for more than one cycle", $time);
        errors++;
    end

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> wb_active)
    else begin
        $display("[ERROR] %0t: ack outside an active bus cycle", $time);
        errors++;
    end

    task automatic finish_run();
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic check_value(input string what, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s is %02h, expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s", name);
        end
        errors_at_start = errors;
    endtask

    // One classic cycle, held until ack
    task automatic bus_access(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                              output logic [7:0] rdat);
        int waited;
        waited = 0;
        rdat   = 8'h00;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(posedge clk);
        while (!wb_rsp.ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!wb_rsp.ack) begin
            $display("Wishbone access to register %0d was never acknowledged", adr);
            errors++;
            finish_run();
        end else begin
            rdat = wb_rsp.dat;
            wb_req <= '{cyc: 1'b0, stb: 1'b0, we: 1'b0, adr: 3'd0, dat: 8'h00};
        end
    endtask

    task automatic write_reg(input logic [2:0] adr, input logic [7:0] dat);
        logic [7:0] ignored;
        bus_access(1'b1, adr, dat, ignored);
    endtask

    task automatic read_reg(input logic [2:0] adr, output logic [7:0] dat);
        bus_access(1'b0, adr, 8'h00, dat);
    endtask

    // Poll the status word until busy drops
    task automatic wait_idle(output logic [7:0] status);
        int polls;
        polls = 0;
        read_reg(REG_STATUS, status);
        while (status[STATUS_BUSY_BIT] && polls < BUSY_TIMEOUT) begin
            read_reg(REG_STATUS, status);
            polls++;
        end
        if (status[STATUS_BUSY_BIT]) begin
            $display("Transaction still busy after %0d status polls", polls);
            errors++;
            finish_run();
        end
    endtask

    initial begin
        wb_req          <= '0;
        rst_n           <= 1'b0;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // Idle bus and clear status out of reset
        check_value("o_scl after reset", {7'd0, dut_scl}, 8'h01);
        check_value("o_sda after reset", {7'd0, dut_sda}, 8'h01);
        check_value("ack after reset", {7'd0, wb_rsp.ack}, 8'h00);
        read_reg(REG_STATUS, rd);
        check_value("busy after reset", {7'd0, rd[STATUS_BUSY_BIT]}, 8'h00);
        check_value("nack after reset", {7'd0, rd[STATUS_NACK_BIT]}, 8'h00);
        report_test("reset state");

        write_reg(REG_SLAVE, {1'b0, SLAVE_ADDR});
        write_reg(REG_ADDR, 8'h3c);
        write_reg(REG_WDATA, 8'ha5);
        read_reg(REG_SLAVE, rd);
        check_value("slave readback", rd, {1'b0, SLAVE_ADDR});
        read_reg(REG_ADDR, rd);
        check_value("register address readback", rd, 8'h3c);
        read_reg(REG_WDATA, rd);
        check_value("write data readback", rd, 8'ha5);
        report_test("register access");

        stops_before = u_slave.stop_count;
        write_reg(REG_CMD, {6'd0, CMD_WRITE});
        wait_idle(rd);
        check_value("nack after write", {7'd0, rd[STATUS_NACK_BIT]}, 8'h00);
        check_value("slave memory at 3c", u_slave.mem[8'h3c], 8'ha5);
        check_value("STOPs in write", 8'(u_slave.stop_count - stops_before), 8'd1);
        report_test("write transaction");

        // Untouched location still holds its preload
        expected     = u_slave.mem[8'h81];
        stops_before = u_slave.stop_count;
        write_reg(REG_ADDR, 8'h81);
        write_reg(REG_CMD, {6'd0, CMD_READ});
        wait_idle(rd);
        check_value("nack after read", {7'd0, rd[STATUS_NACK_BIT]}, 8'h00);
        read_reg(REG_RDATA, rd);
        check_value("read data", rd, expected);
        check_value("read bit seen by slave", {7'd0, u_slave.saw_read_addr}, 8'h01);
        check_value("master NACK on data", {7'd0, u_slave.master_nack}, 8'h01);
        check_value("STOPs in read", 8'(u_slave.stop_count - stops_before), 8'd2);
        report_test("read transaction");

        stops_before = u_slave.stop_count;
        write_reg(REG_SLAVE, {1'b0, ABSENT_ADDR});
        write_reg(REG_CMD, {6'd0, CMD_WRITE});
        wait_idle(rd);
        check_value("nack from absent slave", {7'd0, rd[STATUS_NACK_BIT]}, 8'h01);
        check_value("SCL released", {7'd0, dut_scl}, 8'h01);
        check_value("SDA released", {7'd0, sda_bus}, 8'h01);
        check_value("STOPs after abort", 8'(u_slave.stop_count - stops_before), 8'd1);
        report_test("address NACK");

        // Second command lands while the first is still running
        write_reg(REG_SLAVE, {1'b0, SLAVE_ADDR});
        write_reg(REG_ADDR, 8'h10);
        write_reg(REG_WDATA, 8'h5a);
        stops_before  = u_slave.stop_count;
        starts_before = u_slave.start_count;
        write_reg(REG_CMD, {6'd0, CMD_WRITE});
        write_reg(REG_CMD, {6'd0, CMD_READ});
        wait_idle(rd);
        check_value("nack after busy drop", {7'd0, rd[STATUS_NACK_BIT]}, 8'h00);
        check_value("slave memory at 10", u_slave.mem[8'h10], 8'h5a);
        check_value("STARTs seen", 8'(u_slave.start_count - starts_before), 8'd1);
        check_value("STOPs seen", 8'(u_slave.stop_count - stops_before), 8'd1);
        report_test("command while busy");

        finish_run();
    end

endmodule

`default_nettype wire

// File: vlog.f
i2c_pkg.sv
i2c_bit_timer.sv
i2c_byte_shifter.sv
i2c_sequencer.sv
i2c_wb_regs.sv
i2c_master_top.sv
tb_clk_gen.sv
i2c_slave_model.sv
tb_i2c_master.sv
